// File: all.f
lc3b_isa_pkg.sv
pipe_ctrl_pkg.sv
stage_tracker.sv
branch_resolver.sv
hazard_detection.sv
pc_unit.sv
pipe_ctrl.sv
pipe_ctrl_tb.sv

// File: branch_resolver.sv
module branch_resolver (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_cc_write,
    input  lc3b_isa_pkg::lc3b_nzp    i_cc_value,
    input  lc3b_isa_pkg::lc3b_nzp    i_nzp_wb,
    input  lc3b_isa_pkg::lc3b_opcode i_op_wb,
    output logic                     o_br_enable
);
    import lc3b_isa_pkg::*;

    lc3b_nzp cc_q;

    // code written by the instruction leaving WB
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cc_q <= '0;
        end else if (i_cc_write) begin
            cc_q <= i_cc_value;
        end
    end

    // taken when any requested flag is set; a bubble has nzp 000
    assign o_br_enable = (i_op_wb == op_br) && ((i_nzp_wb & cc_q) != 3'b000);

endmodule

// File: hazard_detection.sv
module hazard_detection (
    input  logic                     i_br_enable,
    input  logic                     i_imem_resp,
    input  logic                     i_dmem_resp,
    input  logic                     i_dmem_read,
    input  logic                     i_dmem_write,
    input  logic                     i_mem_inter_read,
    input  logic                     i_mem_inter_write,
    input  lc3b_isa_pkg::lc3b_opcode i_op_id,
    input  lc3b_isa_pkg::lc3b_opcode i_op_ex,
    input  lc3b_isa_pkg::lc3b_opcode i_op_mem,
    input  lc3b_isa_pkg::lc3b_opcode i_op_mem_inter,
    input  lc3b_isa_pkg::lc3b_opcode i_op_wb,
    input  lc3b_isa_pkg::lc3b_nzp    i_nzp_id,
    input  lc3b_isa_pkg::lc3b_nzp    i_nzp_ex,
    input  lc3b_isa_pkg::lc3b_nzp    i_nzp_mem,
    input  lc3b_isa_pkg::lc3b_nzp    i_nzp_wb,
    output logic                     o_load,
    output logic                     o_load_pc,
    output logic                     o_control_ident_wb,
    output logic                     o_flush,
    output logic                     o_flush_mem_op,
    output logic                     o_imem_read
);
    import lc3b_isa_pkg::*;

    logic mem_op;
    logic br_pending;

    function automatic logic is_transfer(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    // a real branch, not a bubble
    function automatic logic is_cond_br(input lc3b_opcode op, input lc3b_nzp nzp);
        return (op == op_br) && (nzp != 3'b000);
    endfunction

    assign mem_op = i_dmem_read | i_dmem_write;

    // branches still ahead of WB, with WB itself not deciding one
    assign br_pending = (is_cond_br(i_op_id, i_nzp_id) || is_cond_br(i_op_ex, i_nzp_ex) ||
                         is_cond_br(i_op_mem, i_nzp_mem)) && !is_cond_br(i_op_wb, i_nzp_wb);

    // under predict not taken only unconditional transfers stop fetch
    always_comb begin
        o_imem_read        = 1'b1;
        o_control_ident_wb = 1'b0;
        if (is_transfer(i_op_id) || is_transfer(i_op_ex) || is_transfer(i_op_mem)) begin
            o_imem_read = 1'b0;
        end
        if (is_transfer(i_op_wb) || ((i_op_wb == op_br) && i_br_enable)) begin
            o_imem_read        = 1'b0;
            o_control_ident_wb = 1'b1;
        end
    end

    always_comb begin
        case ({i_imem_resp, i_dmem_resp, mem_op})
            // data access outstanding
            3'b001, 3'b101: begin
                o_load    = 1'b0;
                o_load_pc = 1'b0;
            end
            // no fetch, so the PC holds
            3'b000, 3'b011: begin
                o_load    = 1'b1;
                o_load_pc = 1'b0;
            end
            default: begin
                o_load    = 1'b1;
                o_load_pc = 1'b1;
            end
        endcase

        // ldi and sti hold MEM until their second access
        if ((i_op_mem == op_ldi) || (i_op_mem == op_sti)) begin
            o_load    = 1'b0;
            o_load_pc = 1'b0;
        end

        // release on the response to the second access
        if (((i_op_mem_inter == op_ldi) || (i_op_mem_inter == op_sti)) &&
            !i_mem_inter_read && !i_mem_inter_write && i_dmem_resp) begin
            o_load    = 1'b1;
            o_load_pc = i_imem_resp;
        end

        o_flush        = 1'b0;
        o_flush_mem_op = 1'b0;
        if ((i_op_wb == op_br) && i_br_enable) begin
            o_load_pc      = 1'b1;
            o_flush        = 1'b1;
            o_flush_mem_op = 1'b1;
        end else if (is_transfer(i_op_wb)) begin
            o_load_pc = 1'b1;
        end

        // fetch off means nothing to advance past, unless redirecting
        if (!o_imem_read && !o_control_ident_wb) begin
            o_load_pc = 1'b0;
        end

        if (!i_imem_resp && br_pending) begin
            o_load    = 1'b0;
            o_load_pc = 1'b0;
        end
    end

    // a flush always comes with a redirect of the PC
    a_flush_redirect: assert final (!o_flush || (o_control_ident_wb && o_load_pc))
        else $error("flush without a PC redirect");

endmodule

// File: lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // byte-addressed 16-bit word for the PC and jump targets
    typedef logic [15:0] lc3b_word;

    // branch condition field of a br, or the condition code itself
    typedef logic [2:0] lc3b_nzp;

    // instruction bits [15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // a br with nzp 000 never branches, so it doubles as the bubble

    // first fetch address out of reset
    localparam lc3b_word PC_RESET = 16'h0000;

    // instructions are two bytes wide
    localparam lc3b_word PC_STEP = 16'd2;

endpackage

// File: pc_unit.sv
module pc_unit (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_load_pc,
    input  logic                   i_redirect,
    input  lc3b_isa_pkg::lc3b_word i_target,
    output lc3b_isa_pkg::lc3b_word o_pc
);
    import lc3b_isa_pkg::*;

    lc3b_word pc_q;

    // redirect wins over the sequential step
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= PC_RESET;
        end else if (i_load_pc) begin
            if (i_redirect) begin
                pc_q <= i_target;
            end else begin
                pc_q <= pc_q + PC_STEP;
            end
        end
    end

    assign o_pc = pc_q;

    // targets come from outside and must be halfword aligned
    a_pc_even: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !pc_q[0])
        else $error("PC is odd");

endmodule

// File: pipe_ctrl.sv
module pipe_ctrl (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_imem_resp,
    input  lc3b_isa_pkg::lc3b_opcode i_fetch_opcode,
    input  lc3b_isa_pkg::lc3b_nzp    i_fetch_nzp,
    input  logic                     i_dmem_resp,
    input  logic                     i_cc_write,
    input  lc3b_isa_pkg::lc3b_nzp    i_cc_value,
    input  lc3b_isa_pkg::lc3b_word   i_target,
    output logic                     o_imem_read,
    output lc3b_isa_pkg::lc3b_word   o_imem_addr,
    output logic                     o_dmem_read,
    output logic                     o_dmem_write,
    output logic                     o_flush,
    output logic                     o_stall
);
    import lc3b_isa_pkg::*;

    lc3b_opcode op_id, op_ex, op_mem, op_mem_inter, op_wb;
    lc3b_nzp    nzp_id, nzp_ex, nzp_mem, nzp_wb;
    logic       mem_inter_read, mem_inter_write;
    logic       br_enable, load, load_pc, control_ident_wb, flush_mem_op;
    logic       fetch_valid;

    // a response only counts while a fetch is requested
    assign fetch_valid = i_imem_resp & o_imem_read;
    assign o_stall     = ~load;

    stage_tracker u_stage_tracker (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_load(load), .i_flush(flush_mem_op), .i_fetch_valid(fetch_valid),
        .i_fetch_opcode(i_fetch_opcode), .i_fetch_nzp(i_fetch_nzp),
        .i_dmem_resp(i_dmem_resp),
        .o_op_id(op_id), .o_op_ex(op_ex), .o_op_mem(op_mem),
        .o_op_mem_inter(op_mem_inter), .o_op_wb(op_wb),
        .o_nzp_id(nzp_id), .o_nzp_ex(nzp_ex), .o_nzp_mem(nzp_mem), .o_nzp_wb(nzp_wb),
        .o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
        .o_mem_inter_read(mem_inter_read), .o_mem_inter_write(mem_inter_write)
    );

    branch_resolver u_branch_resolver (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_cc_write(i_cc_write), .i_cc_value(i_cc_value),
        .i_nzp_wb(nzp_wb), .i_op_wb(op_wb),
        .o_br_enable(br_enable)
    );

    hazard_detection u_hazard_detection (
        .i_br_enable(br_enable), .i_imem_resp(fetch_valid), .i_dmem_resp(i_dmem_resp),
        .i_dmem_read(o_dmem_read), .i_dmem_write(o_dmem_write),
        .i_mem_inter_read(mem_inter_read), .i_mem_inter_write(mem_inter_write),
        .i_op_id(op_id), .i_op_ex(op_ex), .i_op_mem(op_mem),
        .i_op_mem_inter(op_mem_inter), .i_op_wb(op_wb),
        .i_nzp_id(nzp_id), .i_nzp_ex(nzp_ex), .i_nzp_mem(nzp_mem), .i_nzp_wb(nzp_wb),
        .o_load(load), .o_load_pc(load_pc), .o_control_ident_wb(control_ident_wb),
        .o_flush(o_flush), .o_flush_mem_op(flush_mem_op), .o_imem_read(o_imem_read)
    );

    pc_unit u_pc_unit (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_load_pc(load_pc), .i_redirect(control_ident_wb), .i_target(i_target),
        .o_pc(o_imem_addr)
    );

endmodule

// File: pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // progress of an ldi or sti through the MEM stage
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_FIRST,
        MEM_GAP,
        MEM_SECOND
    } mem_phase_e;

    // tracked stages are ID, EX, MEM and WB
    localparam int NUM_STAGES = 4;

endpackage

// File: pipe_ctrl_tb.sv
module pipe_ctrl_tb;
    import lc3b_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_ROWS        = 17;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 10;

    logic       i_clk;
    logic       i_arst_n;
    logic       i_imem_resp;
    lc3b_opcode i_fetch_opcode;
    lc3b_nzp    i_fetch_nzp;
    logic       i_dmem_resp;
    logic       i_cc_write;
    lc3b_nzp    i_cc_value;
    lc3b_word   i_target;
    logic       o_imem_read;
    lc3b_word   o_imem_addr;
    logic       o_dmem_read;
    logic       o_dmem_write;
    logic       o_flush;
    logic       o_stall;

    // stimulus columns where a cc of 000 means no cc write
    lc3b_opcode tbl_op [NUM_ROWS];
    lc3b_nzp    tbl_nzp [NUM_ROWS];
    lc3b_nzp    tbl_cc [NUM_ROWS];
    lc3b_word   tbl_target [NUM_ROWS];
    int         tbl_imem_delay [NUM_ROWS];
    int         tbl_dmem_delay [NUM_ROWS];
    // expected columns from the reference model
    lc3b_word   tbl_start_pc [NUM_ROWS];
    lc3b_word   tbl_exp_pc [NUM_ROWS];
    int         tbl_exp_flushes [NUM_ROWS];
    int         tbl_exp_accesses [NUM_ROWS];

    int       row_count;
    int       cur_row;
    int       seed;
    int       value_errors;
    int       other_errors;
    int       flush_count;
    int       read_count;
    int       write_count;
    int       dmem_delay;
    int       dmem_wait;
    logic     data_row;
    logic     s_stall;
    logic     s_imem_read;
    logic     s_dmem_read;
    logic     s_dmem_write;
    logic     s_flush;
    lc3b_word s_pc;
    logic     prev_stall;
    lc3b_word prev_pc;

    pipe_ctrl u_pipe_ctrl (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_imem_resp(i_imem_resp), .i_fetch_opcode(i_fetch_opcode),
        .i_fetch_nzp(i_fetch_nzp), .i_dmem_resp(i_dmem_resp),
        .i_cc_write(i_cc_write), .i_cc_value(i_cc_value), .i_target(i_target),
        .o_imem_read(o_imem_read), .o_imem_addr(o_imem_addr),
        .o_dmem_read(o_dmem_read), .o_dmem_write(o_dmem_write),
        .o_flush(o_flush), .o_stall(o_stall)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all rows were applied");
        $display("Done: errors found");
        $finish;
    end

    function automatic logic is_transfer_op(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    function automatic logic is_cond_branch(input lc3b_opcode op, input lc3b_nzp nzp);
        return (op == op_br) && (nzp != 3'b000);
    endfunction

    function automatic logic is_load_op(input lc3b_opcode op);
        return (op == op_ldr) || (op == op_ldb) || (op == op_ldi);
    endfunction

    function automatic int data_accesses(input lc3b_opcode op);
        if ((op == op_ldi) || (op == op_sti)) begin
            return 2;
        end
        if ((op == op_ldr) || (op == op_ldb) || (op == op_str) || (op == op_stb)) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
        end
    endtask

    task automatic add_row(input lc3b_opcode op, input lc3b_nzp nzp, input lc3b_nzp cc,
                           input lc3b_word target);
        tbl_op[row_count]         = op;
        tbl_nzp[row_count]        = nzp;
        tbl_cc[row_count]         = cc;
        tbl_target[row_count]     = target;
        tbl_imem_delay[row_count] = {$random(seed)} % 4;
        tbl_dmem_delay[row_count] = {$random(seed)} % 4;
        row_count++;
    endtask

    // predict-not-taken rules applied row by row
    task automatic build_expected;
        lc3b_word pc;
        lc3b_nzp  cc;
        pc = PC_RESET;
        cc = 3'b000;
        for (int r = 0; r < row_count; r++) begin
            tbl_start_pc[r]     = pc;
            tbl_exp_flushes[r]  = 0;
            tbl_exp_accesses[r] = data_accesses(tbl_op[r]);
            if (is_transfer_op(tbl_op[r])) begin
                pc = tbl_target[r];
            end else if (is_cond_branch(tbl_op[r], tbl_nzp[r])) begin
                if ((tbl_nzp[r] & cc) != 3'b000) begin
                    pc = tbl_target[r];
                    tbl_exp_flushes[r] = 1;
                end else begin
                    // the branch itself plus the bubbles fetched behind it
                    pc = pc + NUM_STAGES * PC_STEP;
                end
            end else begin
                pc = pc + PC_STEP;
            end
            tbl_exp_pc[r] = pc;
            if (tbl_cc[r] != 3'b000) begin
                cc = tbl_cc[r];
            end
        end
    endtask

    task automatic run_cycle(input logic imem_resp, input lc3b_opcode op, input lc3b_nzp nzp,
                             input logic cc_write);
        @(negedge i_clk);
        i_imem_resp    = imem_resp;
        i_fetch_opcode = op;
        i_fetch_nzp    = nzp;
        i_cc_write     = cc_write;
        i_cc_value     = tbl_cc[cur_row];
        i_target       = tbl_target[cur_row];
        @(posedge i_clk);
        // values the edge acts on
        s_stall      = o_stall;
        s_imem_read  = o_imem_read;
        s_dmem_read  = o_dmem_read;
        s_dmem_write = o_dmem_write;
        s_flush      = o_flush;
        s_pc         = o_imem_addr;
        if (prev_stall) begin
            check_word("o_imem_addr", s_pc, prev_pc);
        end
        if ((s_dmem_read || s_dmem_write) && !i_dmem_resp) begin
            check_bit("o_stall", s_stall, 1'b1);
        end
        if (!data_row) begin
            check_bit("o_stall", s_stall, 1'b0);
        end
        if (s_flush) begin
            flush_count++;
        end
        prev_stall = s_stall;
        prev_pc    = s_pc;
    endtask

    task automatic apply_row(input int r);
        int   advances;
        int   exp_reads;
        int   exp_writes;
        logic cond_br;
        cur_row     = r;
        cond_br     = is_cond_branch(tbl_op[r], tbl_nzp[r]);
        data_row    = (data_accesses(tbl_op[r]) != 0);
        dmem_delay  = tbl_dmem_delay[r];
        flush_count = 0;
        read_count  = 0;
        write_count = 0;
        exp_reads   = is_load_op(tbl_op[r]) ? tbl_exp_accesses[r] : 0;
        exp_writes  = is_load_op(tbl_op[r]) ? 0 : tbl_exp_accesses[r];
        // PC must hold while the fetch response is missing
        repeat (tbl_imem_delay[r]) begin
            run_cycle(1'b0, op_br, 3'b000, 1'b0);
            check_word("o_imem_addr", s_pc, tbl_start_pc[r]);
        end
        run_cycle(1'b1, tbl_op[r], tbl_nzp[r], 1'b0);
        check_word("o_imem_addr", s_pc, tbl_start_pc[r]);
        check_bit("o_imem_read", s_imem_read, 1'b1);
        advances = 0;
        while (advances < NUM_STAGES) begin
            // an unresolved branch needs fetched bubbles behind it
            run_cycle(cond_br && (advances < NUM_STAGES - 1), op_br, 3'b000, 1'b0);
            if (is_transfer_op(tbl_op[r])) begin
                check_bit("o_imem_read", s_imem_read, 1'b0);
            end
            if (!s_stall) begin
                advances++;
            end
        end
        // pipeline is empty again and the row's cc is written
        run_cycle(1'b0, op_br, 3'b000, tbl_cc[r] != 3'b000);
        check_word("o_imem_addr", s_pc, tbl_exp_pc[r]);
        check_bit("o_imem_read", s_imem_read, 1'b1);
        check_bit("o_dmem_read", s_dmem_read, 1'b0);
        check_bit("o_dmem_write", s_dmem_write, 1'b0);
        check_bit("o_flush", s_flush, 1'b0);
        check_int("flush count", flush_count, tbl_exp_flushes[r]);
        check_int("data reads", read_count, exp_reads);
        check_int("data writes", write_count, exp_writes);
    endtask

    // data memory answers each access after the row's delay
    always @(negedge i_clk) begin
        if (i_dmem_resp) begin
            i_dmem_resp = 1'b0;
            dmem_wait   = 0;
            if (o_dmem_read || o_dmem_write) begin
                other_errors++;
                $display("row %0d: data access right after a response, no idle cycle", cur_row);
            end
        end else if (o_dmem_read || o_dmem_write) begin
            if (dmem_wait >= dmem_delay) begin
                i_dmem_resp = 1'b1;
                dmem_wait   = 0;
                if (o_dmem_read) begin
                    read_count++;
                end else begin
                    write_count++;
                end
            end else begin
                dmem_wait++;
            end
        end else begin
            dmem_wait = 0;
        end
    end

    initial begin
        seed           = 90;
        value_errors   = 0;
        other_errors   = 0;
        row_count      = 0;
        cur_row        = 0;
        data_row       = 1'b0;
        dmem_delay     = 0;
        dmem_wait      = 0;
        flush_count    = 0;
        read_count     = 0;
        write_count    = 0;
        prev_stall     = 1'b0;
        prev_pc        = PC_RESET;
        i_arst_n       = 1'b0;
        i_imem_resp    = 1'b0;
        i_fetch_opcode = op_br;
        i_fetch_nzp    = 3'b000;
        i_dmem_resp    = 1'b0;
        i_cc_write     = 1'b0;
        i_cc_value     = 3'b000;
        i_target       = PC_RESET;

        add_row(op_add, 3'b000, 3'b001, 16'h0000);
        add_row(op_and, 3'b000, 3'b010, 16'h0000);
        add_row(op_not, 3'b000, 3'b100, 16'h0000);
        add_row(op_shf, 3'b000, 3'b001, 16'h0000);
        add_row(op_ldr, 3'b000, 3'b001, 16'h0000);
        add_row(op_str, 3'b000, 3'b000, 16'h0000);
        add_row(op_ldb, 3'b000, 3'b010, 16'h0000);
        add_row(op_stb, 3'b000, 3'b000, 16'h0000);
        add_row(op_ldi, 3'b000, 3'b100, 16'h0000);
        add_row(op_sti, 3'b000, 3'b000, 16'h0000);
        // cc is n here, so this one is taken
        add_row(op_br, 3'b100, 3'b000, 16'h0100);
        add_row(op_br, 3'b011, 3'b000, 16'h0200);
        add_row(op_jmp, 3'b000, 3'b000, 16'h0300);
        add_row(op_lea, 3'b000, 3'b010, 16'h0000);
        add_row(op_br, 3'b010, 3'b000, 16'h0040);
        add_row(op_jsr, 3'b000, 3'b000, 16'h0080);
        add_row(op_trap, 3'b000, 3'b000, 16'h0020);
        build_expected();

        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;

        run_cycle(1'b0, op_br, 3'b000, 1'b0);
        check_word("o_imem_addr", s_pc, PC_RESET);
        check_bit("o_imem_read", s_imem_read, 1'b1);
        check_bit("o_dmem_read", s_dmem_read, 1'b0);
        check_bit("o_dmem_write", s_dmem_write, 1'b0);
        check_bit("o_flush", s_flush, 1'b0);

        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: stage_tracker.sv
module stage_tracker (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_load,
    input  logic                    i_flush,
    input  logic                    i_fetch_valid,
    input  lc3b_isa_pkg::lc3b_opcode i_fetch_opcode,
    input  lc3b_isa_pkg::lc3b_nzp    i_fetch_nzp,
    input  logic                    i_dmem_resp,
    output lc3b_isa_pkg::lc3b_opcode o_op_id,
    output lc3b_isa_pkg::lc3b_opcode o_op_ex,
    output lc3b_isa_pkg::lc3b_opcode o_op_mem,
    output lc3b_isa_pkg::lc3b_opcode o_op_mem_inter,
    output lc3b_isa_pkg::lc3b_opcode o_op_wb,
    output lc3b_isa_pkg::lc3b_nzp    o_nzp_id,
    output lc3b_isa_pkg::lc3b_nzp    o_nzp_ex,
    output lc3b_isa_pkg::lc3b_nzp    o_nzp_mem,
    output lc3b_isa_pkg::lc3b_nzp    o_nzp_wb,
    output logic                    o_dmem_read,
    output logic                    o_dmem_write,
    output logic                    o_mem_inter_read,
    output logic                    o_mem_inter_write
);
    import lc3b_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    // index 0 is ID, 3 is WB
    lc3b_opcode op_q [NUM_STAGES];
    lc3b_nzp    nzp_q [NUM_STAGES];

    mem_phase_e phase_q;
    mem_phase_e phase_d;
    logic       access;

    function automatic logic is_indirect(input lc3b_opcode op);
        return (op == op_ldi) || (op == op_sti);
    endfunction

    function automatic logic is_read(input lc3b_opcode op);
        return (op == op_ldr) || (op == op_ldb) || (op == op_ldi);
    endfunction

    function automatic logic is_write(input lc3b_opcode op);
        return (op == op_str) || (op == op_stb) || (op == op_sti);
    endfunction

    // flush squashes everything younger than the branch leaving WB
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                op_q[s]  <= op_br;
                nzp_q[s] <= '0;
            end
        end else if (i_flush) begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                op_q[s]  <= op_br;
                nzp_q[s] <= '0;
            end
        end else if (i_load) begin
            // no fetch this cycle means a bubble enters ID
            op_q[0]  <= i_fetch_valid ? i_fetch_opcode : op_br;
            nzp_q[0] <= i_fetch_valid ? i_fetch_nzp : '0;
            for (int s = 1; s < NUM_STAGES; s++) begin
                op_q[s]  <= op_q[s-1];
                nzp_q[s] <= nzp_q[s-1];
            end
        end
    end

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            MEM_FIRST: begin
                if (i_dmem_resp) begin
                    phase_d = MEM_GAP;
                end
            end
            // one idle cycle between the pointer read and the data access
            MEM_GAP: phase_d = MEM_SECOND;
            default: ;
        endcase
        // a shift brings a new op into MEM
        if (i_load) begin
            phase_d = is_indirect(op_q[1]) ? MEM_FIRST : MEM_IDLE;
        end
        if (i_flush) begin
            phase_d = MEM_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase_q <= MEM_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // plain loads and stores access in IDLE, indirect ones in FIRST and SECOND
    assign access = !i_flush && ((phase_q == MEM_FIRST) || (phase_q == MEM_SECOND) ||
                    ((phase_q == MEM_IDLE) && !is_indirect(op_q[2])));

    assign o_dmem_read       = access && is_read(op_q[2]);
    assign o_dmem_write      = access && is_write(op_q[2]);
    assign o_mem_inter_read  = (phase_q == MEM_FIRST) && is_read(op_q[2]);
    assign o_mem_inter_write = (phase_q == MEM_FIRST) && is_write(op_q[2]);

    // visible only once the first access is done
    assign o_op_mem_inter = ((phase_q == MEM_GAP) || (phase_q == MEM_SECOND)) ? op_q[2] : op_br;

    assign o_op_id  = op_q[0];
    assign o_op_ex  = op_q[1];
    assign o_op_mem = op_q[2];
    assign o_op_wb  = op_q[3];
    assign o_nzp_id  = nzp_q[0];
    assign o_nzp_ex  = nzp_q[1];
    assign o_nzp_mem = nzp_q[2];
    assign o_nzp_wb  = nzp_q[3];

    a_rw_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_dmem_read && o_dmem_write))
        else $error("data memory read and write both high");

endmodule
